// File: hw/write_engine_pkg.sv
//////////////////////////////////////////////////
// Write engine shared definitions
// Widths, buffer depths and command codes
// Tag, half line, WED, command and packet structs
// Size and ordering attribute mapping functions
//////////////////////////////////////////////////

`default_nettype none

package write_engine_pkg;

	//////////////////////////////////////////////////
	// Sizes and constants
	//////////////////////////////////////////////////

	localparam int DATA_FIFO_DEPTH = 16;
	localparam int CMD_FIFO_DEPTH  = 8;
	// Two pipeline stages plus one pop in flight
	localparam int CMD_HEADROOM    = 3;

	localparam logic [3:0] CU_ID_WRITE  = 4'h3;
	localparam logic [7:0] CMD_WRITE_NA = 8'h20;
	localparam logic [7:0] CMD_WRITE_MS = 8'h21;

	typedef logic [63:0] addr_t;
	typedef logic [63:0] half_data_t;
	typedef logic [7:0]  real_size_t;
	typedef logic [11:0] cmd_size_t;
	typedef logic [2:0]  abt_t;
	typedef logic [31:0] byte_count_t;

	localparam abt_t ABT_STRICT = 3'd0;

	//////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////

	typedef struct packed {
		addr_t      address_offset;
		real_size_t real_size;
		logic [3:0] cu_id;
	} write_tag_t;

	typedef struct packed {
		logic       valid;
		write_tag_t tag;
		half_data_t data;
	} data_half_t;

	typedef struct packed {
		logic        valid;
		addr_t       array_base;
		// Bit 4 selects MS, bits 2..0 the abt
		logic [15:0] afu_config;
	} wed_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
	} buffer_status_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] command;
		addr_t      address;
		cmd_size_t  size;
		abt_t       abt;
		write_tag_t tag;
	} write_command_t;

	typedef struct packed {
		write_command_t command;
		half_data_t     data_0;
		half_data_t     data_1;
	} write_packet_t;

	typedef struct packed {
		logic       valid;
		real_size_t real_size;
	} write_response_t;

	//////////////////////////////////////////////////
	// Mapping functions
	//////////////////////////////////////////////////

	// Smallest power of two covering the real size
	function automatic cmd_size_t cmd_size_for(input real_size_t real_size);
		cmd_size_t size;
		size = cmd_size_t'(128);
		for (int i = 7; i >= 0; i--) begin
			if (int'(real_size) <= (1 << i)) begin
				size = cmd_size_t'(1 << i);
			end
		end
		return size;
	endfunction

	// Config codes above 4 are not legal attributes
	function automatic abt_t abt_map(input logic [2:0] config_abt);
		if (config_abt > 3'd4) begin
			return ABT_STRICT;
		end
		return abt_t'(config_abt);
	endfunction

endpackage

`default_nettype wire

// File: hw/sync_fifo.sv
//////////////////////////////////////////////////
// Synchronous first-word-fall-through FIFO
// Full, almost-full and empty flags
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH    = 8,
	parameter int DEPTH    = 16,
	parameter int HEADROOM = 2
) (
	input  wire              clock,
	input  wire              rstn,
	input  wire              push,
	input  wire  [WIDTH-1:0] data_in,
	input  wire              pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full     = (count == COUNT_BITS'(DEPTH));
	assign alfull   = (count >= COUNT_BITS'(DEPTH - HEADROOM));
	assign empty    = (count == '0);
	assign data_out = mem[rd_ptr];

	// Storage only, no reset
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/write_engine_control.sv
//////////////////////////////////////////////////
// Write engine control
// Buffers and pairs the two half lines
// Builds write commands from the latched WED
// Accumulates completed response bytes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_engine_control (
	input  wire                                clock,
	input  wire                                rstn,
	input  wire                                enabled_in,
	input  wire write_engine_pkg::wed_t          wed_in,
	input  wire write_engine_pkg::data_half_t    data_0_in,
	input  wire write_engine_pkg::data_half_t    data_1_in,
	input  wire write_engine_pkg::write_response_t response_in,
	input  wire write_engine_pkg::buffer_status_t  cmd_buffer_status,
	output write_engine_pkg::buffer_status_t       data_buffer_status,
	output logic                                 packet_push,
	output write_engine_pkg::write_packet_t        packet_data,
	output write_engine_pkg::byte_count_t          bytes_done
);

	logic                             enabled;
	logic                             data_pop;
	write_engine_pkg::wed_t           wed_latched;
	write_engine_pkg::data_half_t     head_0;
	write_engine_pkg::data_half_t     head_1;
	write_engine_pkg::buffer_status_t fifo_0_status;
	write_engine_pkg::buffer_status_t fifo_1_status;
	write_engine_pkg::write_packet_t  packet_next;
	write_engine_pkg::write_packet_t  stage_1;

	assign data_buffer_status = fifo_0_status;

	//////////////////////////////////////////////////
	// WED latch and enable
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_latched <= '0;
		end else if (wed_in.valid) begin
			wed_latched <= wed_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	//////////////////////////////////////////////////
	// Response byte counter
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			bytes_done <= '0;
		end else if (response_in.valid) begin
			bytes_done <= bytes_done + write_engine_pkg::byte_count_t'(response_in.real_size);
		end
	end

	//////////////////////////////////////////////////
	// Command formation
	//////////////////////////////////////////////////

	// Whole line present and room downstream
	assign data_pop = !fifo_0_status.empty && !fifo_1_status.empty &&
		!cmd_buffer_status.alfull && enabled;

	always_comb begin
		packet_next                   = '0;
		packet_next.command.valid     = 1'b1;
		packet_next.command.address   = wed_latched.array_base + head_0.tag.address_offset;
		packet_next.command.size      = write_engine_pkg::cmd_size_for(head_0.tag.real_size);
		packet_next.command.abt       = write_engine_pkg::abt_map(wed_latched.afu_config[2:0]);
		packet_next.command.tag       = head_0.tag;
		packet_next.command.tag.cu_id = write_engine_pkg::CU_ID_WRITE;
		if (wed_latched.afu_config[4]) begin
			packet_next.command.command = write_engine_pkg::CMD_WRITE_MS;
		end else begin
			packet_next.command.command = write_engine_pkg::CMD_WRITE_NA;
		end
		packet_next.data_0 = head_0.data;
		packet_next.data_1 = head_1.data;
	end

	// Stage 1 holds the formed command, stage 2 drives the push
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stage_1     <= '0;
			packet_data <= '0;
			packet_push <= 1'b0;
		end else begin
			stage_1     <= data_pop ? packet_next : '0;
			packet_data <= stage_1;
			packet_push <= stage_1.command.valid;
		end
	end

	//////////////////////////////////////////////////
	// Half line buffers
	//////////////////////////////////////////////////

	sync_fifo #(
		.WIDTH   ($bits(write_engine_pkg::data_half_t)),
		.DEPTH   (write_engine_pkg::DATA_FIFO_DEPTH),
		.HEADROOM(write_engine_pkg::CMD_HEADROOM)
	) u_data_0_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (data_0_in.valid),
		.data_in (data_0_in),
		.pop     (data_pop),
		.data_out(head_0),
		.full    (fifo_0_status.full),
		.alfull  (fifo_0_status.alfull),
		.empty   (fifo_0_status.empty)
	);

	sync_fifo #(
		.WIDTH   ($bits(write_engine_pkg::data_half_t)),
		.DEPTH   (write_engine_pkg::DATA_FIFO_DEPTH),
		.HEADROOM(write_engine_pkg::CMD_HEADROOM)
	) u_data_1_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (data_1_in.valid),
		.data_in (data_1_in),
		.pop     (data_pop),
		.data_out(head_1),
		.full    (fifo_1_status.full),
		.alfull  (fifo_1_status.alfull),
		.empty   (fifo_1_status.empty)
	);

endmodule

`default_nettype wire

// File: hw/write_engine_top.sv
//////////////////////////////////////////////////
// Write engine top level
// Control block feeding the outgoing command buffer
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_engine_top (
	input  wire                                  clock,
	input  wire                                  rstn,
	input  wire                                  enabled_in,
	input  wire write_engine_pkg::wed_t            wed_in,
	input  wire write_engine_pkg::data_half_t      data_0_in,
	input  wire write_engine_pkg::data_half_t      data_1_in,
	input  wire write_engine_pkg::write_response_t response_in,
	input  wire                                  packet_pop,
	output write_engine_pkg::write_packet_t        packet_out,
	output logic                                 packet_empty,
	output write_engine_pkg::buffer_status_t       data_buffer_status,
	output write_engine_pkg::byte_count_t          bytes_done
);

	logic                             packet_push;
	write_engine_pkg::write_packet_t  packet_data;
	write_engine_pkg::buffer_status_t cmd_buffer_status;

	assign packet_empty = cmd_buffer_status.empty;

	write_engine_control u_control (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.wed_in            (wed_in),
		.data_0_in         (data_0_in),
		.data_1_in         (data_1_in),
		.response_in       (response_in),
		.cmd_buffer_status (cmd_buffer_status),
		.data_buffer_status(data_buffer_status),
		.packet_push       (packet_push),
		.packet_data       (packet_data),
		.bytes_done        (bytes_done)
	);

	// Outgoing packets, drained by the consumer
	sync_fifo #(
		.WIDTH   ($bits(write_engine_pkg::write_packet_t)),
		.DEPTH   (write_engine_pkg::CMD_FIFO_DEPTH),
		.HEADROOM(write_engine_pkg::CMD_HEADROOM)
	) u_cmd_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (packet_push),
		.data_in (packet_data),
		.pop     (packet_pop),
		.data_out(packet_out),
		.full    (cmd_buffer_status.full),
		.alfull  (cmd_buffer_status.alfull),
		.empty   (cmd_buffer_status.empty)
	);

endmodule

`default_nettype wire

// File: test/write_engine_chk.sv
//////////////////////////////////////////////////
// Concurrent checks on the write engine top level
// Pop and push legality, head valid, byte counter
// Bound into write_engine_top
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_engine_chk (
	input wire                                  clock,
	input wire                                  rstn,
	input wire                                  packet_pop,
	input wire                                  packet_empty,
	input wire                                  packet_push,
	input wire                                  cmd_full,
	input wire write_engine_pkg::write_packet_t packet_out,
	input wire write_engine_pkg::byte_count_t   bytes_done
);

	// Number of failed properties so far
	int fail_count = 0;

	a_pop_needs_data: assert property (@(posedge clock) disable iff (!rstn)
		packet_pop |-> !packet_empty)
		else begin
			fail_count++;
			$error("packet_pop while the command buffer is empty");
		end

	a_no_push_full: assert property (@(posedge clock) disable iff (!rstn)
		packet_push |-> !cmd_full)
		else begin
			fail_count++;
			$error("Command buffer pushed while full");
		end

	// Head of the buffer always carries a formed command
	a_head_valid: assert property (@(posedge clock) disable iff (!rstn)
		!packet_empty |-> packet_out.command.valid)
		else begin
			fail_count++;
			$error("Head packet without valid bit");
		end

	a_bytes_monotonic: assert property (@(posedge clock) disable iff (!rstn)
		bytes_done >= $past(bytes_done))
		else begin
			fail_count++;
			$error("bytes_done decreased");
		end

endmodule

bind write_engine_top write_engine_chk u_chk (
	.clock       (clock),
	.rstn        (rstn),
	.packet_pop  (packet_pop),
	.packet_empty(packet_empty),
	.packet_push (packet_push),
	.cmd_full    (cmd_buffer_status.full),
	.packet_out  (packet_out),
	.bytes_done  (bytes_done)
);

`default_nettype wire

// File: test/tb_write_engine.sv
//////////////////////////////////////////////////
// Testbench for the write engine top level
// Clock, reset and stimulus tasks
// Reference packet model and compare process
// Per-test report lines and closing summary
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_write_engine;

	// Roughly eight times the length of all tests together
	localparam int MAX_CYCLES = 4000;

	logic                              clock;
	logic                              rstn;
	logic                              enabled_in;
	write_engine_pkg::wed_t            wed_in;
	write_engine_pkg::data_half_t      data_0_in;
	write_engine_pkg::data_half_t      data_1_in;
	write_engine_pkg::write_response_t response_in;
	logic                              packet_pop;
	write_engine_pkg::write_packet_t   packet_out;
	logic                              packet_empty;
	write_engine_pkg::buffer_status_t  data_buffer_status;
	write_engine_pkg::byte_count_t     bytes_done;

	integer                          seed = 32'h5867_f058;
	int                              errors = 0;
	int                              checks = 0;
	int                              cycles = 0;
	int                              lines_complete = 0;
	int                              rx_count = 0;
	logic                            pop_allowed;
	write_engine_pkg::wed_t          wed_model;
	write_engine_pkg::byte_count_t   bytes_expected;
	write_engine_pkg::write_packet_t exp_q[$];

	write_engine_top u_dut (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.wed_in            (wed_in),
		.data_0_in         (data_0_in),
		.data_1_in         (data_1_in),
		.response_in       (response_in),
		.packet_pop        (packet_pop),
		.packet_out        (packet_out),
		.packet_empty      (packet_empty),
		.data_buffer_status(data_buffer_status),
		.bytes_done        (bytes_done)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles with %0d packets still expected", cycles,
				exp_q.size());
			$display("TB FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic write_engine_pkg::write_packet_t expected_packet(
		input write_engine_pkg::wed_t     wed,
		input write_engine_pkg::data_half_t h0,
		input write_engine_pkg::data_half_t h1
	);
		write_engine_pkg::write_packet_t p;
		int size;
		p = '0;
		p.command.valid = 1'b1;
		if (wed.afu_config[4]) begin
			p.command.command = write_engine_pkg::CMD_WRITE_MS;
		end else begin
			p.command.command = write_engine_pkg::CMD_WRITE_NA;
		end
		p.command.address = wed.array_base + h0.tag.address_offset;
		// Double until the real size is covered
		size = 1;
		while (size < int'(h0.tag.real_size)) begin
			size = size * 2;
		end
		p.command.size = write_engine_pkg::cmd_size_t'(size);
		if (wed.afu_config[2:0] <= 3'd4) begin
			p.command.abt = wed.afu_config[2:0];
		end else begin
			p.command.abt = write_engine_pkg::ABT_STRICT;
		end
		p.command.tag       = h0.tag;
		p.command.tag.cu_id = write_engine_pkg::CU_ID_WRITE;
		p.data_0            = h0.data;
		p.data_1            = h1.data;
		return p;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
		end
		#1;
	endtask

	// New random line, expected packet queued right away
	task automatic make_line(output write_engine_pkg::data_half_t h0,
		output write_engine_pkg::data_half_t h1);
		h0.valid              = 1'b1;
		h0.tag.address_offset = {$random(seed), $random(seed)} & ~64'h7f;
		h0.tag.real_size      = write_engine_pkg::real_size_t'(1 + ($unsigned($random(seed)) % 128));
		h0.tag.cu_id          = 4'($random(seed));
		h0.data               = {$random(seed), $random(seed)};
		h1                    = h0;
		h1.data               = {$random(seed), $random(seed)};
		exp_q.push_back(expected_packet(wed_model, h0, h1));
	endtask

	task automatic strobe_halves(input logic use_0, input logic use_1,
		input write_engine_pkg::data_half_t h0, input write_engine_pkg::data_half_t h1);
		@(posedge clock);
		#1;
		if (use_0) begin
			data_0_in = h0;
		end
		if (use_1) begin
			data_1_in = h1;
		end
		@(posedge clock);
		#1;
		data_0_in = '0;
		data_1_in = '0;
	endtask

	task automatic send_line();
		write_engine_pkg::data_half_t h0;
		write_engine_pkg::data_half_t h1;
		make_line(h0, h1);
		strobe_halves(1'b1, 1'b1, h0, h1);
		lines_complete++;
	endtask

	task automatic send_skewed();
		write_engine_pkg::data_half_t h0 [4];
		write_engine_pkg::data_half_t h1 [4];
		write_engine_pkg::data_half_t a;
		write_engine_pkg::data_half_t b;
		int                           rnd;
		int                           gap;
		logic                         first;
		// Half 0 of several lines runs ahead
		for (int i = 0; i < 4; i++) begin
			make_line(h0[i], h1[i]);
			strobe_halves(1'b1, 1'b0, h0[i], h1[i]);
		end
		idle_cycles(6);
		for (int i = 0; i < 4; i++) begin
			strobe_halves(1'b0, 1'b1, h0[i], h1[i]);
			lines_complete++;
		end
		// Random order and gap inside each line
		for (int i = 0; i < 8; i++) begin
			make_line(a, b);
			rnd   = $random(seed);
			first = rnd[0];
			gap   = int'($unsigned($random(seed)) % 6);
			strobe_halves(first, !first, a, b);
			idle_cycles(gap);
			strobe_halves(!first, first, a, b);
			lines_complete++;
		end
	endtask

	task automatic load_wed(input logic ms, input logic [2:0] abt_cfg);
		write_engine_pkg::wed_t w;
		w.valid      = 1'b1;
		w.array_base = {$random(seed), $random(seed)};
		w.afu_config = {11'd0, ms, 1'b0, abt_cfg};
		@(posedge clock);
		#1;
		wed_in    = w;
		wed_model = w;
		@(posedge clock);
		#1;
		wed_in = '0;
	endtask

	task automatic send_response();
		write_engine_pkg::real_size_t size;
		size = write_engine_pkg::real_size_t'(1 + ($unsigned($random(seed)) % 128));
		@(posedge clock);
		#1;
		response_in.valid     = 1'b1;
		response_in.real_size = size;
		bytes_expected        = bytes_expected + write_engine_pkg::byte_count_t'(size);
		@(posedge clock);
		#1;
		response_in = '0;
	endtask

	// Consumer side changes away from the compare instant
	task automatic set_popping(input logic on);
		@(negedge clock);
		pop_allowed = on;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clock);
		end
		idle_cycles(4);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	//////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////

	task automatic check_head();
		write_engine_pkg::write_packet_t exp;
		if (exp_q.size() == 0) begin
			errors++;
			$display("Unexpected packet at %0t with nothing left to expect", $time);
			return;
		end
		exp = exp_q.pop_front();
		checks++;
		assert (packet_out == exp) else begin
			errors++;
			$display("MISMATCH at %0t: packet %0d got addr %h size %0d abt %0d cmd %h d0 %h",
				$time, rx_count, packet_out.command.address, packet_out.command.size,
				packet_out.command.abt, packet_out.command.command, packet_out.data_0);
			$display("  expected addr %h size %0d abt %0d cmd %h d0 %h", exp.command.address,
				exp.command.size, exp.command.abt, exp.command.command, exp.data_0);
		end
		checks++;
		assert (rx_count < lines_complete) else begin
			errors++;
			$display("Packet %0d came out before both of its halves were sent", rx_count);
		end
		rx_count++;
	endtask

	// Head checked one step after the edge, popped on the next one
	initial begin
		packet_pop = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			packet_pop = 1'b0;
			if (rstn && pop_allowed && !packet_empty) begin
				check_head();
				packet_pop = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int                               mark;
		write_engine_pkg::buffer_status_t status_exp;
		clock          = 1'b0;
		rstn           = 1'b0;
		enabled_in     = 1'b0;
		wed_in         = '0;
		data_0_in      = '0;
		data_1_in      = '0;
		response_in    = '0;
		pop_allowed    = 1'b1;
		wed_model      = '0;
		bytes_expected = '0;
		repeat (3) begin
			@(posedge clock);
		end
		#1;
		rstn = 1'b1;
		checks++;
		assert (packet_empty && bytes_done == '0) else begin
			errors++;
			$display("MISMATCH at %0t: after reset packet_empty %b bytes_done %0d", $time,
				packet_empty, bytes_done);
		end
		enabled_in = 1'b1;

		mark = errors;
		load_wed(1'b0, 3'd2);
		for (int i = 0; i < 20; i++) begin
			send_line();
		end
		wait_drain();
		report_test("basic formation", mark);

		mark = errors;
		send_skewed();
		wait_drain();
		report_test("skewed halves", mark);

		mark = errors;
		for (int abt_cfg = 5; abt_cfg <= 7; abt_cfg++) begin
			load_wed(1'b1, 3'(abt_cfg));
			for (int i = 0; i < 6; i++) begin
				send_line();
			end
			wait_drain();
		end
		report_test("config mapping", mark);

		mark = errors;
		set_popping(1'b0);
		for (int i = 0; i < 12; i++) begin
			send_line();
		end
		idle_cycles(10);
		checks++;
		assert (!packet_empty && !data_buffer_status.full) else begin
			errors++;
			$display("MISMATCH at %0t: stalled with packet_empty %b data full %b", $time,
				packet_empty, data_buffer_status.full);
		end
		set_popping(1'b1);
		wait_drain();
		report_test("back-pressure", mark);

		mark = errors;
		@(posedge clock);
		#1;
		enabled_in = 1'b0;
		// Fill both half-line buffers to the brim
		for (int i = 0; i < write_engine_pkg::DATA_FIFO_DEPTH; i++) begin
			send_line();
		end
		for (int i = 0; i < 50; i++) begin
			idle_cycles(1);
			checks++;
			assert (packet_empty) else begin
				errors++;
				$display("MISMATCH at %0t: packet present while disabled", $time);
			end
		end
		// A full buffer is almost full too
		status_exp.full   = 1'b1;
		status_exp.alfull = 1'b1;
		status_exp.empty  = 1'b0;
		checks++;
		assert (data_buffer_status == status_exp) else begin
			errors++;
			$display("MISMATCH at %0t: data buffer status %b expected %b while disabled",
				$time, data_buffer_status, status_exp);
		end
		enabled_in = 1'b1;
		wait_drain();
		status_exp.full   = 1'b0;
		status_exp.alfull = 1'b0;
		status_exp.empty  = 1'b1;
		checks++;
		assert (data_buffer_status == status_exp) else begin
			errors++;
			$display("MISMATCH at %0t: data buffer status %b expected %b after drain",
				$time, data_buffer_status, status_exp);
		end
		report_test("enable gate", mark);

		mark = errors;
		for (int i = 0; i < 30; i++) begin
			send_response();
		end
		checks++;
		assert (bytes_done == bytes_expected) else begin
			errors++;
			$display("MISMATCH at %0t: bytes_done %0d expected %0d", $time, bytes_done,
				bytes_expected);
		end
		report_test("response counting", mark);

		// Failed properties of the bound checker count as errors
		errors = errors + u_dut.u_chk.fail_count;

		$display("Summary: %0d checks, %0d errors, %0d packets received", checks, errors,
			rx_count);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hw/write_engine_pkg.sv
hw/sync_fifo.sv
hw/write_engine_control.sv
hw/write_engine_top.sv
test/write_engine_chk.sv
test/tb_write_engine.sv

// File: Makefile
# Verilator build and run for the write engine testbench

VERILATOR ?= verilator
TOP       ?= tb_write_engine
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TB PASSED

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The log decides pass or fail
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
